// ==== rtl/lsq_pkg.sv ====
`default_nettype none

package lsq_pkg;

    localparam int ID_W     = 4;
    localparam int OFFSET_W = 6;
    localparam int PAGE_W   = 4;
    localparam int DATA_W   = 32;
    localparam int WADDR_W  = PAGE_W + OFFSET_W;
    localparam int HASH_W   = 3;

    // Low offset bits used for the load/store collision check
    typedef logic [HASH_W-1:0] addr_hash_t;

    typedef struct packed {
        logic [ID_W-1:0]     id;
        logic                store;
        logic [OFFSET_W-1:0] offset;
        logic [DATA_W-1:0]   data;
    } lsq_req_t;

    typedef struct packed {
        logic [PAGE_W-1:0] page;
        logic              store;
        logic              discard;
    } lsq_addr_t;

    // Store index field is fixed at 4 bits, store queue depth up to 16
    typedef struct packed {
        logic [ID_W-1:0]     id;
        logic [OFFSET_W-1:0] offset;
        logic                collision;
        logic [3:0]          sq_idx;
    } lq_entry_t;

    typedef struct packed {
        logic [PAGE_W-1:0] page;
        logic              discard;
    } page_entry_t;

    typedef struct packed {
        logic               we;
        logic [WADDR_W-1:0] addr;
        logic [DATA_W-1:0]  data;
        logic [ID_W-1:0]    id;
    } mem_req_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
    } load_resp_t;

endpackage

`default_nettype wire

// ==== rtl/lsq_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_fifo #(
    parameter type DATA_TYPE = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  logic     pop,
    input  DATA_TYPE data_in,
    output DATA_TYPE data_out,
    output logic     valid,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    DATA_TYPE         mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Head is read straight from the array
    assign data_out = mem[rd_ptr];
    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));

    ////////////////////////////////////////////////////////////
    // Assertions
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> valid);

endmodule

`default_nettype wire

// ==== rtl/lsq_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_dispatch
    import lsq_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  lsq_req_t    req,
    input  logic        addr_valid,
    input  lsq_addr_t   addr,
    output logic        lq_push,
    output logic        sq_push,
    output lsq_req_t    entry_req,
    output logic        lq_addr_push,
    output logic        sq_addr_push,
    output page_entry_t page_in,
    output addr_hash_t  hash
);

    // Request side, split by kind
    assign lq_push   = req_valid & ~req.store;
    assign sq_push   = req_valid & req.store;
    assign entry_req = req;

    // Address side, split by kind
    assign lq_addr_push = addr_valid & ~addr.store;
    assign sq_addr_push = addr_valid & addr.store;
    assign page_in      = '{page: addr.page, discard: addr.discard};

    // Hash taken from the low word offset bits
    assign hash = req.offset[HASH_W-1:0];

    ////////////////////////////////////////////////////////////
    // Assertions
    a_req_kind_known: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> !$isunknown(req.store));
    a_addr_kind_known: assert property (@(posedge clk) disable iff (rst)
        addr_valid |-> !$isunknown({addr.store, addr.discard}));

endmodule

`default_nettype wire

// ==== rtl/load_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_queue
    import lsq_pkg::*;
#(
    parameter int DEPTH    = 8,
    parameter int SQ_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  lsq_req_t                    entry_req,
    input  logic                        addr_push,
    input  page_entry_t                 page_in,
    input  logic                        collision,
    input  logic [$clog2(SQ_DEPTH)-1:0] sq_tail,
    input  logic [$clog2(SQ_DEPTH)-1:0] sq_oldest,
    input  logic                        grant,
    output mem_req_t                    mem_req,
    output logic                        mem_valid,
    output logic                        credit
);

    localparam int SQ_IDX_W = $clog2(SQ_DEPTH);

    lq_entry_t   entry_in;
    lq_entry_t   head;
    page_entry_t head_page;
    logic        entry_valid;
    logic        page_valid;
    logic        addr_ok;
    logic        blocked;
    logic        discard;
    logic        pop;

    // Record the collision and the store tail at enqueue
    assign entry_in = '{
        id:        entry_req.id,
        offset:    entry_req.offset,
        collision: collision,
        sq_idx:    4'(sq_tail)
    };

    lsq_fifo #(.DATA_TYPE(lq_entry_t), .DEPTH(DEPTH)) entry_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .pop      (pop),
        .data_in  (entry_in),
        .data_out (head),
        .valid    (entry_valid),
        .full     ()
    );

    lsq_fifo #(.DATA_TYPE(page_entry_t), .DEPTH(DEPTH)) page_fifo_i (
        .clk      (clk),
        .rst      (rst),
        .push     (addr_push),
        .pop      (pop),
        .data_in  (page_in),
        .data_out (head_page),
        .valid    (page_valid),
        .full     ()
    );

    ////////////////////////////////////////////////////////////
    // Head control
    assign addr_ok = entry_valid & page_valid;
    // Colliding load waits until its older stores have drained
    assign blocked = head.collision & (head.sq_idx[SQ_IDX_W-1:0] != sq_oldest);
    assign discard = addr_ok & head_page.discard;

    assign mem_valid = addr_ok & ~head_page.discard & ~blocked;
    assign pop       = grant | discard;
    assign credit    = pop;

    assign mem_req = '{
        we:   1'b0,
        addr: {head_page.page, head.offset},
        data: '0,
        id:   head.id
    };

endmodule

`default_nettype wire

// ==== rtl/store_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_queue
    import lsq_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  lsq_req_t                 entry_req,
    input  addr_hash_t               hash,
    input  logic                     addr_push,
    input  page_entry_t              page_in,
    input  logic                     store_retire,
    output logic                     collision,
    output logic [$clog2(DEPTH)-1:0] sq_tail,
    output logic [$clog2(DEPTH)-1:0] sq_oldest,
    input  logic                     grant,
    output mem_req_t                 mem_req,
    output logic                     mem_valid,
    output logic                     credit
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [IDX_W-1:0]    head;
    logic [IDX_W-1:0]    tail;
    logic [IDX_W-1:0]    addr_ptr;
    logic [IDX_W-1:0]    ret_ptr;
    logic [DEPTH-1:0]    busy;
    logic [DEPTH-1:0]    retired;
    logic [DEPTH-1:0]    addr_ok;
    logic [DEPTH-1:0]    discard_q;
    logic [DATA_W-1:0]   data_q   [DEPTH];
    logic [OFFSET_W-1:0] offset_q [DEPTH];
    logic [PAGE_W-1:0]   page_q   [DEPTH];
    addr_hash_t          hash_q   [DEPTH];
    logic                ready;
    logic                drop;
    logic                pop;

    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        if (idx == IDX_W'(DEPTH - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Slot state
    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= '0;
            tail     <= '0;
            addr_ptr <= '0;
            ret_ptr  <= '0;
            busy     <= '0;
            retired  <= '0;
            addr_ok  <= '0;
        end else begin
            if (push) begin
                busy[tail]    <= 1'b1;
                retired[tail] <= 1'b0;
                addr_ok[tail] <= 1'b0;
                tail          <= next_idx(tail);
            end
            // Address may land in the slot pushed this same cycle
            if (addr_push) begin
                addr_ok[addr_ptr] <= 1'b1;
                addr_ptr          <= next_idx(addr_ptr);
            end
            if (store_retire) begin
                retired[ret_ptr] <= 1'b1;
                ret_ptr          <= next_idx(ret_ptr);
            end
            if (pop) begin
                busy[head] <= 1'b0;
                head       <= next_idx(head);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data_q[tail]   <= entry_req.data;
            offset_q[tail] <= entry_req.offset;
            hash_q[tail]   <= hash;
        end
        if (addr_push) begin
            page_q[addr_ptr]    <= page_in.page;
            discard_q[addr_ptr] <= page_in.discard;
        end
    end

    // Any pending store with the same hash flags the incoming load
    always_comb begin
        collision = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (busy[i] && (hash_q[i] == hash)) begin
                collision = 1'b1;
            end
        end
    end

    assign sq_tail   = tail;
    assign sq_oldest = head;

    ////////////////////////////////////////////////////////////
    // Head offer and drop
    assign ready     = busy[head] & retired[head] & addr_ok[head];
    assign mem_valid = ready & ~discard_q[head];
    assign drop      = ready & discard_q[head];
    assign pop       = grant | drop;
    assign credit    = pop;

    assign mem_req = '{
        we:   1'b1,
        addr: {page_q[head], offset_q[head]},
        data: data_q[head],
        id:   '0
    };

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        push |-> !busy[tail]);
    a_retire_pending: assert property (@(posedge clk) disable iff (rst)
        store_retire |-> busy[ret_ptr] && !retired[ret_ptr]);

endmodule

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import lsq_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              lq_valid,
    input  mem_req_t          lq_mem,
    input  logic              sq_valid,
    input  mem_req_t          sq_mem,
    output logic              lq_grant,
    output logic              sq_grant,
    output mem_req_t          ram_req,
    output logic              ram_en,
    input  logic [DATA_W-1:0] ram_rdata,
    output logic              resp_valid,
    output load_resp_t        resp
);

    logic [ID_W-1:0] resp_id;

    // Loads always win, a store goes only on an idle load side
    assign lq_grant = lq_valid;
    assign sq_grant = sq_valid & ~lq_valid;

    assign ram_req = lq_grant ? lq_mem : sq_mem;
    assign ram_en  = lq_grant | sq_grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= lq_grant;
        end
    end

    // Id travels alongside the one-cycle RAM read
    always_ff @(posedge clk) begin
        if (lq_grant) begin
            resp_id <= lq_mem.id;
        end
    end

    assign resp = '{id: resp_id, data: ram_rdata};

endmodule

`default_nettype wire

// ==== rtl/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram
    import lsq_pkg::*;
(
    input  logic              clk,
    input  logic              en,
    input  mem_req_t          req,
    output logic [DATA_W-1:0] rdata
);

    localparam int WORDS = 1 << WADDR_W;

    logic [DATA_W-1:0] mem [WORDS];

    // Known contents for simulation
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            if (req.we) begin
                mem[req.addr] <= req.data;
            end else begin
                rdata <= mem[req.addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lsq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsq_top
    import lsq_pkg::*;
#(
    parameter int LQ_DEPTH = 8,
    parameter int SQ_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  lsq_req_t   req,
    input  logic       addr_valid,
    input  lsq_addr_t  addr,
    input  logic       store_retire,
    output logic       lq_credit,
    output logic       sq_credit,
    output logic       resp_valid,
    output load_resp_t resp
);

    logic                        lq_push;
    logic                        sq_push;
    lsq_req_t                    entry_req;
    logic                        lq_addr_push;
    logic                        sq_addr_push;
    page_entry_t                 page_in;
    addr_hash_t                  hash;
    logic                        collision;
    logic [$clog2(SQ_DEPTH)-1:0] sq_tail;
    logic [$clog2(SQ_DEPTH)-1:0] sq_oldest;
    logic                        lq_valid;
    logic                        sq_valid;
    mem_req_t                    lq_mem;
    mem_req_t                    sq_mem;
    logic                        lq_grant;
    logic                        sq_grant;
    mem_req_t                    ram_req;
    logic                        ram_en;
    logic [DATA_W-1:0]           ram_rdata;

    lsq_dispatch dispatch_i (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .addr_valid   (addr_valid),
        .addr         (addr),
        .lq_push      (lq_push),
        .sq_push      (sq_push),
        .entry_req    (entry_req),
        .lq_addr_push (lq_addr_push),
        .sq_addr_push (sq_addr_push),
        .page_in      (page_in),
        .hash         (hash)
    );

    load_queue #(.DEPTH(LQ_DEPTH), .SQ_DEPTH(SQ_DEPTH)) load_queue_i (
        .clk       (clk),
        .rst       (rst),
        .push      (lq_push),
        .entry_req (entry_req),
        .addr_push (lq_addr_push),
        .page_in   (page_in),
        .collision (collision),
        .sq_tail   (sq_tail),
        .sq_oldest (sq_oldest),
        .grant     (lq_grant),
        .mem_req   (lq_mem),
        .mem_valid (lq_valid),
        .credit    (lq_credit)
    );

    store_queue #(.DEPTH(SQ_DEPTH)) store_queue_i (
        .clk          (clk),
        .rst          (rst),
        .push         (sq_push),
        .entry_req    (entry_req),
        .hash         (hash),
        .addr_push    (sq_addr_push),
        .page_in      (page_in),
        .store_retire (store_retire),
        .collision    (collision),
        .sq_tail      (sq_tail),
        .sq_oldest    (sq_oldest),
        .grant        (sq_grant),
        .mem_req      (sq_mem),
        .mem_valid    (sq_valid),
        .credit       (sq_credit)
    );

    mem_arbiter arbiter_i (
        .clk        (clk),
        .rst        (rst),
        .lq_valid   (lq_valid),
        .lq_mem     (lq_mem),
        .sq_valid   (sq_valid),
        .sq_mem     (sq_mem),
        .lq_grant   (lq_grant),
        .sq_grant   (sq_grant),
        .ram_req    (ram_req),
        .ram_en     (ram_en),
        .ram_rdata  (ram_rdata),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    data_ram ram_i (
        .clk   (clk),
        .en    (ram_en),
        .req   (ram_req),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_lsq.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsq
    import lsq_pkg::*;
();

    localparam int LQ_DEPTH        = 8;
    localparam int SQ_DEPTH        = 4;
    localparam int CLK_PERIOD      = 100;
    localparam int N_TESTS         = 6;
    localparam int CYCLES_PER_TEST = 400;
    localparam int N_RANDOM        = 48;

    logic       clk;
    logic       rst;
    logic       req_valid;
    lsq_req_t   req;
    logic       addr_valid;
    lsq_addr_t  addr;
    logic       store_retire;
    logic       lq_credit;
    logic       sq_credit;
    logic       resp_valid;
    load_resp_t resp;

    // Reference memory holds stores in program order
    logic [DATA_W-1:0] ref_mem   [1 << WADDR_W];
    logic [DATA_W-1:0] exp_data  [16];
    logic              exp_valid [16];
    logic [ID_W-1:0]   next_id;
    int                outstanding;
    int                lq_cred;
    int                sq_cred;
    int                lq_pulses;
    int                sq_pulses;
    int                unretired;
    int                errors;
    int                seed;

    lsq_top #(.LQ_DEPTH(LQ_DEPTH), .SQ_DEPTH(SQ_DEPTH)) lsq_top_i (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .addr_valid   (addr_valid),
        .addr         (addr),
        .store_retire (store_retire),
        .lq_credit    (lq_credit),
        .sq_credit    (sq_credit),
        .resp_valid   (resp_valid),
        .resp         (resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("ERROR: watchdog expired, the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Checking helpers
    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Credit returns and responses, sampled on the rising edge
    always @(posedge clk) begin
        if (!rst) begin
            if (lq_credit) begin
                lq_cred++;
                lq_pulses++;
            end
            if (sq_credit) begin
                sq_cred++;
                sq_pulses++;
            end
            if (lq_cred > LQ_DEPTH || sq_cred > SQ_DEPTH) begin
                report_error("more credits returned than were spent");
            end
            if (resp_valid) begin
                if (!exp_valid[resp.id]) begin
                    report_error($sformatf("response for id %0d with no pending load",
                                           resp.id));
                end else begin
                    check_value($sformatf("resp.data (id %0d)", resp.id),
                                resp.data, exp_data[resp.id]);
                    exp_valid[resp.id] = 1'b0;
                    outstanding--;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    task automatic drive_cycle(input logic rv, input lsq_req_t r, input logic av,
                               input lsq_addr_t a, input logic ret);
        req_valid    = rv;
        req          = r;
        addr_valid   = av;
        addr         = a;
        store_retire = ret;
        @(posedge clk);
        #1;
        req_valid    = 1'b0;
        addr_valid   = 1'b0;
        store_retire = 1'b0;
    endtask

    task automatic idle_cycle(input logic ret);
        if (ret) begin
            unretired--;
        end
        drive_cycle(1'b0, '0, 1'b0, '0, ret);
    endtask

    task automatic retire_store();
        if (unretired == 0) begin
            report_error("retire requested with no unretired store");
        end else begin
            idle_cycle(1'b1);
        end
    endtask

    task automatic send_addr(input logic [PAGE_W-1:0] pg, input logic store,
                             input logic discard);
        lsq_addr_t a;
        a = '{page: pg, store: store, discard: discard};
        drive_cycle(1'b0, '0, 1'b1, a, 1'b0);
    endtask

    task automatic issue_load(input logic [PAGE_W-1:0] pg, input logic [OFFSET_W-1:0] word_off,
                              input logic discard, input logic with_addr, input logic ret);
        lsq_req_t  r;
        lsq_addr_t a;
        if (lq_cred == 0) begin
            report_error("load issue attempted without a load credit");
            return;
        end
        r = '{id: next_id, store: 1'b0, offset: word_off, data: '0};
        a = '{page: pg, store: 1'b0, discard: discard};
        if (!discard) begin
            if (exp_valid[next_id]) begin
                report_error("load id reused while still pending");
            end
            exp_valid[next_id] = 1'b1;
            exp_data[next_id]  = ref_mem[{pg, word_off}];
            outstanding++;
        end
        if (ret) begin
            unretired--;
        end
        lq_cred--;
        next_id = next_id + 1'b1;
        drive_cycle(1'b1, r, with_addr, a, ret);
    endtask

    task automatic issue_store(input logic [PAGE_W-1:0] pg, input logic [OFFSET_W-1:0] word_off,
                               input logic [DATA_W-1:0] wdata, input logic discard,
                               input logic with_addr, input logic ret);
        lsq_req_t  r;
        lsq_addr_t a;
        if (sq_cred == 0) begin
            report_error("store issue attempted without a store credit");
            return;
        end
        r = '{id: next_id, store: 1'b1, offset: word_off, data: wdata};
        a = '{page: pg, store: 1'b1, discard: discard};
        if (!discard) begin
            ref_mem[{pg, word_off}] = wdata;
        end
        if (ret) begin
            unretired--;
        end
        unretired++;
        sq_cred--;
        next_id = next_id + 1'b1;
        drive_cycle(1'b1, r, with_addr, a, ret);
    endtask

    // Wait for all responses, and for every credit if full_drain is set
    task automatic wait_done(input logic full_drain, input string what);
        int n;
        n = 0;
        while (!(outstanding == 0 &&
                 (!full_drain || (lq_cred == LQ_DEPTH && sq_cred == SQ_DEPTH)))) begin
            if (n == CYCLES_PER_TEST) begin
                report_error({what, " did not complete in time"});
                return;
            end
            @(posedge clk);
            #1;
            n++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    task automatic test_store_then_load();
        issue_store(4'd1, 6'd5, 32'hA5A5_0001, 1'b0, 1'b0, 1'b0);
        send_addr(4'd1, 1'b1, 1'b0);
        retire_store();
        issue_load(4'd1, 6'd5, 1'b0, 1'b1, 1'b0);
        wait_done(1'b1, "store then load");
    endtask

    task automatic test_collision_blocks();
        logic [ID_W-1:0] load_id;
        issue_store(4'd0, 6'd10, 32'h1234_5678, 1'b0, 1'b1, 1'b0);
        load_id = next_id;
        issue_load(4'd0, 6'd10, 1'b0, 1'b1, 1'b0);
        repeat (10) idle_cycle(1'b0);
        if (!exp_valid[load_id]) begin
            report_error("colliding load answered before its store retired");
        end
        retire_store();
        wait_done(1'b1, "colliding load");
    endtask

    task automatic test_no_collision_bypass();
        // Hash 2 store stays unretired while the hash 5 load reads
        issue_store(4'd1, 6'd2, 32'h0BAD_F00D, 1'b0, 1'b1, 1'b0);
        issue_load(4'd1, 6'd5, 1'b0, 1'b1, 1'b0);
        wait_done(1'b0, "non-colliding load");
        retire_store();
        wait_done(1'b1, "store drain after bypass");
    endtask

    task automatic test_discard();
        int lq_before;
        int sq_before;
        lq_before = lq_pulses;
        sq_before = sq_pulses;
        issue_store(4'd1, 6'd5, 32'hDEAD_BEEF, 1'b1, 1'b1, 1'b0);
        retire_store();
        issue_load(4'd1, 6'd5, 1'b1, 1'b1, 1'b0);
        wait_done(1'b1, "discard");
        check_value("lq_credit pulses", lq_pulses - lq_before, 1);
        check_value("sq_credit pulses", sq_pulses - sq_before, 1);
        issue_load(4'd1, 6'd5, 1'b0, 1'b1, 1'b0);
        wait_done(1'b1, "read after discard");
    endtask

    task automatic test_fill_and_drain();
        int lq_before;
        int sq_before;
        lq_before = lq_pulses;
        sq_before = sq_pulses;
        // Loads on page 2 and stores on page 3 never overlap
        for (int i = 0; i < LQ_DEPTH; i++) begin
            issue_load(4'd2, OFFSET_W'(i), 1'b0, 1'b0, 1'b0);
        end
        for (int i = 0; i < SQ_DEPTH; i++) begin
            issue_store(4'd3, OFFSET_W'(i), 32'hC0DE_0000 + i, 1'b0, 1'b0, 1'b0);
        end
        repeat (4) idle_cycle(1'b0);
        check_value("lq_credit pulses while full", lq_pulses - lq_before, 0);
        check_value("sq_credit pulses while full", sq_pulses - sq_before, 0);
        for (int i = 0; i < LQ_DEPTH; i++) begin
            send_addr(4'd2, 1'b0, 1'b0);
        end
        for (int i = 0; i < SQ_DEPTH; i++) begin
            send_addr(4'd3, 1'b1, 1'b0);
        end
        while (unretired > 0) begin
            retire_store();
        end
        wait_done(1'b1, "fill and drain");
        check_value("lq_credit pulses", lq_pulses - lq_before, LQ_DEPTH);
        check_value("sq_credit pulses", sq_pulses - sq_before, SQ_DEPTH);
    endtask

    task automatic test_random_mix();
        logic [31:0]         r;
        logic [DATA_W-1:0]   wdata;
        logic [PAGE_W-1:0]   pg;
        logic [OFFSET_W-1:0] word_off;
        logic                is_store;
        logic                discard;
        logic                ret;
        for (int n = 0; n < N_RANDOM; n++) begin
            r        = $random(seed);
            wdata    = $random(seed);
            is_store = r[0];
            pg       = PAGE_W'(r[1]);
            word_off = OFFSET_W'(r[5:2]);
            discard  = (r[9:7] == 3'b000);
            // A load also waits for a free store slot to tag its collision
            while (is_store ? (sq_cred == 0) : (lq_cred == 0 || sq_cred == 0)) begin
                idle_cycle(unretired > 0);
            end
            ret = (unretired > 0) && r[10];
            if (is_store) begin
                issue_store(pg, word_off, wdata, discard, 1'b1, ret);
            end else begin
                issue_load(pg, word_off, discard, 1'b1, ret);
            end
        end
        while (unretired > 0) begin
            retire_store();
        end
        wait_done(1'b1, "random mix");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        errors       = 0;
        outstanding  = 0;
        lq_cred      = LQ_DEPTH;
        sq_cred      = SQ_DEPTH;
        lq_pulses    = 0;
        sq_pulses    = 0;
        unretired    = 0;
        seed         = 32'h515;
        next_id      = '0;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        addr_valid   = 1'b0;
        addr         = '0;
        store_retire = 1'b0;
        for (int i = 0; i < (1 << WADDR_W); i++) begin
            ref_mem[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            exp_valid[i] = 1'b0;
            exp_data[i]  = '0;
        end

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        test_store_then_load();
        test_collision_blocks();
        test_no_collision_bypass();
        test_discard();
        test_fill_and_drain();
        test_random_mix();

        $display("tb_lsq finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/lsq_pkg.sv
rtl/lsq_fifo.sv
rtl/lsq_dispatch.sv
rtl/load_queue.sv
rtl/store_queue.sv
rtl/mem_arbiter.sv
rtl/data_ram.sv
rtl/lsq_top.sv
testbench/tb_lsq.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lsq
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	test $$status -eq 0 && ! grep -q "TESTS FAILED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
